// File: Makefile
# Verilator flow for the post-processing stage

VERILATOR  ?= verilator
TOP        := tb_pp_top
RTL_TOP    := pp_top
FILELIST   := list.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing
PASS_MSG   := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the testbench printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_pp_top.sv
`timescale 1ns/1ps

`include "pp_regs.svh"

module tb_pp_top;

  import pp_pkg::*;

  localparam int unsigned lanes     = 4;
  localparam int unsigned num_lanes = num_groups * lanes;
  localparam int unsigned vec_w     = num_lanes * acc_width;
  localparam int unsigned out_w     = num_lanes * q_width;
  localparam int          wait_limit = 64;
  localparam int          num_rows   = 12;

  // one directed case
  typedef struct packed {
    logic                   mode;
    logic [shift_width-1:0] lo;
    logic [shift_width-1:0] hi;
    logic [bias_width-1:0]  b0;
    logic [bias_width-1:0]  b1;
    logic [acc_width-1:0]   g0;
    logic [acc_width-1:0]   g1;
    logic                   fill;
  } row_t;

  logic                      clk;
  logic                      rst_n;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [apb_addr_width-1:0] paddr;
  logic [apb_data_width-1:0] pwdata;
  logic [apb_data_width-1:0] prdata;
  logic                      pready;
  logic                      pslverr;
  logic                      acc_valid;
  logic [vec_w-1:0]          acc_vector;
  logic                      out_valid;
  logic [out_w-1:0]          out_vector;

  // scoreboard state
  logic [out_w-1:0] exp_q [$];
  int               stamp_q [$];
  int               cyc = 0;
  int               checks = 0;
  int               mismatches = 0;
  int               other_errs = 0;
  int               sent = 0;
  integer           seed;

  // config as last programmed
  logic                   cfg_mode;
  logic [shift_width-1:0] cfg_lo;
  logic [shift_width-1:0] cfg_hi;
  logic [bias_width-1:0]  cfg_b0;
  logic [bias_width-1:0]  cfg_b1;

  row_t tbl [num_rows];

  pp_top #(
    .lanes_per_group (lanes)
  ) u_pp_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .acc_valid  (acc_valid),
    .acc_vector (acc_vector),
    .out_valid  (out_valid),
    .out_vector (out_vector)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // bias, relu, truncating shift, clamp to 255
  function automatic logic [q_width-1:0] quant_ref(input logic [acc_width-1:0] acc,
                                                   input logic [bias_width-1:0] bias,
                                                   input logic [shift_width-1:0] sh);
    logic signed [acc_width-1:0]  acc_s;
    logic signed [bias_width-1:0] bias_s;
    longint                       sum;
    longint                       shifted;
    acc_s   = acc;
    bias_s  = bias;
    sum     = longint'(acc_s) + longint'(bias_s);
    if (sum < 0) return '0;
    shifted = sum >>> sh;
    if (shifted > 255) return 8'hff;
    return shifted[q_width-1:0];
  endfunction

  function automatic logic [out_w-1:0] expect_vector(input logic [vec_w-1:0] vec,
                                                     input logic m,
                                                     input logic [shift_width-1:0] lo,
                                                     input logic [shift_width-1:0] hi,
                                                     input logic [bias_width-1:0] b0,
                                                     input logic [bias_width-1:0] b1);
    logic [out_w-1:0]       res;
    logic [shift_width-1:0] sh;
    logic [bias_width-1:0]  b;
    int                     idx;
    res = '0;
    for (int g = 0; g < num_groups; g++) begin
      // group 1 takes the high scale only in 1x8
      sh = (g == 0 || !m) ? lo : hi;
      b  = (g == 0) ? b0 : b1;
      for (int l = 0; l < lanes; l++) begin
        idx = g * lanes + l;
        res[idx*q_width +: q_width] = quant_ref(vec[idx*acc_width +: acc_width], b, sh);
      end
    end
    return res;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // apb driver
  //////////////////////////////////////////////////////////////////////

  task automatic apb_access(input logic wr, input logic [apb_addr_width-1:0] addr,
                            input logic [apb_data_width-1:0] wdata,
                            output logic [apb_data_width-1:0] rdata, output logic err);
    int waited;
    // setup phase
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    // access phase
    @(posedge clk);
    penable <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (!pready && waited < wait_limit) begin
      @(negedge clk);
      waited++;
    end
    assert (pready) else begin
      other_errs++;
      $display("APB access to 0x%02h timed out waiting for pready", addr);
    end
    rdata = prdata;
    err   = pslverr;
    // write lands on this edge
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic write_reg(input logic [apb_addr_width-1:0] addr,
                           input logic [apb_data_width-1:0] data, input logic exp_err);
    logic [apb_data_width-1:0] rdata;
    logic                      err;
    apb_access(1'b1, addr, data, rdata, err);
    checks++;
    assert (err == exp_err) else begin
      mismatches++;
      $display("MISMATCH pslverr write 0x%02h exp 0x%0h got 0x%0h", addr, exp_err, err);
    end
  endtask

  task automatic read_check(input logic [apb_addr_width-1:0] addr,
                            input logic [apb_data_width-1:0] exp_data, input logic exp_err);
    logic [apb_data_width-1:0] rdata;
    logic                      err;
    apb_access(1'b0, addr, '0, rdata, err);
    checks++;
    assert (err == exp_err) else begin
      mismatches++;
      $display("MISMATCH pslverr read 0x%02h exp 0x%0h got 0x%0h", addr, exp_err, err);
    end
    // data only meaningful on a good access
    if (!exp_err) begin
      checks++;
      assert (rdata == exp_data) else begin
        mismatches++;
        $display("MISMATCH prdata 0x%02h exp 0x%08h got 0x%08h", addr, exp_data, rdata);
      end
    end
  endtask

  task automatic program_config(input logic m, input logic [shift_width-1:0] lo,
                                input logic [shift_width-1:0] hi,
                                input logic [bias_width-1:0] b0,
                                input logic [bias_width-1:0] b1);
    write_reg(`PP_CTRL, {31'b0, m} << `PP_CTRL_MODE_BIT, 1'b0);
    // lo in [4:0], hi in [12:8]
    write_reg(`PP_SCALE, {19'b0, hi, 3'b0, lo}, 1'b0);
    write_reg(`PP_BIAS, {b1, b0}, 1'b0);
    cfg_mode = m;
    cfg_lo   = lo;
    cfg_hi   = hi;
    cfg_b0   = b0;
    cfg_b1   = b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stream driver
  //////////////////////////////////////////////////////////////////////

  // spread of magnitudes, not just full-scale values
  task automatic random_lane(output logic [acc_width-1:0] lane);
    logic [31:0]                 rnd;
    logic signed [acc_width-1:0] raw;
    rnd  = $random(seed);
    raw  = rnd[acc_width-1:0];
    lane = raw >>> rnd[27:24];
  endtask

  task automatic build_vector(input logic [acc_width-1:0] g0, input logic [acc_width-1:0] g1,
                              input logic fill, input logic all_rand,
                              output logic [vec_w-1:0] vec);
    logic [acc_width-1:0] lane;
    vec = '0;
    for (int g = 0; g < num_groups; g++) begin
      for (int l = 0; l < lanes; l++) begin
        if (all_rand || (fill && l != 0)) begin
          random_lane(lane);
        end else begin
          lane = (g == 0) ? g0 : g1;
        end
        vec[(g*lanes + l)*acc_width +: acc_width] = lane;
      end
    end
  endtask

  task automatic send_vector(input logic [vec_w-1:0] vec);
    @(posedge clk);
    acc_valid  <= 1'b1;
    acc_vector <= vec;
    exp_q.push_back(expect_vector(vec, cfg_mode, cfg_lo, cfg_hi, cfg_b0, cfg_b1));
    sent++;
  endtask

  task automatic end_stream();
    @(posedge clk);
    acc_valid  <= 1'b0;
    acc_vector <= '0;
  endtask

  // wait until every vector in flight has come out
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < wait_limit) begin
      @(posedge clk);
      waited++;
    end
    assert (exp_q.size() == 0) else begin
      other_errs++;
      $display("timed out waiting for out_valid, %0d vectors never came out", exp_q.size());
      exp_q.delete();
      stamp_q.delete();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // output monitor
  //////////////////////////////////////////////////////////////////////

  // negedge sampling, one cycle count per clock
  always @(negedge clk) begin
    int               stamp;
    logic [out_w-1:0] exp_vec;
    if (rst_n) begin
      cyc = cyc + 1;
      if (acc_valid) begin
        stamp_q.push_back(cyc);
      end
      if (out_valid) begin
        assert (exp_q.size() != 0 && stamp_q.size() != 0) else begin
          other_errs++;
          $display("out_valid high with no vector in flight at cycle %0d", cyc);
        end
        if (exp_q.size() != 0 && stamp_q.size() != 0) begin
          exp_vec = exp_q.pop_front();
          stamp   = stamp_q.pop_front();
          checks++;
          // two stages, two cycles
          assert (cyc - stamp == 2) else begin
            mismatches++;
            $display("MISMATCH out_valid latency exp 0x2 got 0x%0h", cyc - stamp);
          end
          for (int l = 0; l < num_lanes; l++) begin
            checks++;
            assert (out_vector[l*q_width +: q_width] == exp_vec[l*q_width +: q_width]) else begin
              mismatches++;
              $display("MISMATCH out_vector lane %0d exp 0x%02h got 0x%02h", l,
                       exp_vec[l*q_width +: q_width], out_vector[l*q_width +: q_width]);
            end
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////////////

  task automatic load_table();
    // mode lo hi bias0 bias1 lane0 group 0, lane0 group 1, random fill
    tbl[0]  = '{1'b0, 5'd0,  5'd0,  16'd0,      16'd0,       24'd100,    24'd255,    1'b0};
    // saturation at shift 0
    tbl[1]  = '{1'b0, 5'd0,  5'd0,  16'd0,      16'd0,       24'd256,    24'd70000,  1'b0};
    // positive acc pushed negative by the bias
    tbl[2]  = '{1'b0, 5'd0,  5'd0,  -16'sd50,   -16'sd200,   24'd30,     24'd150,    1'b0};
    tbl[3]  = '{1'b0, 5'd2,  5'd0,  16'd0,      16'd10,      -24'sd1000, -24'sd5,    1'b0};
    // shift 7, in range and just over
    tbl[4]  = '{1'b0, 5'd7,  5'd0,  16'd0,      16'd0,       24'd12345,  24'd32895,  1'b0};
    tbl[5]  = '{1'b0, 5'd7,  5'd0,  16'd100,    -16'sd100,   24'd32667,  24'd32995,  1'b0};
    // shift 31
    tbl[6]  = '{1'b0, 5'd31, 5'd0,  16'h7fff,   16'd0,       24'h7fffff, 24'h000001, 1'b0};
    // same data, mode 0 then mode 1
    tbl[7]  = '{1'b0, 5'd2,  5'd6,  16'd0,      16'd0,       24'd400,    24'd400,    1'b0};
    tbl[8]  = '{1'b1, 5'd2,  5'd6,  16'd0,      16'd0,       24'd400,    24'd400,    1'b0};
    tbl[9]  = '{1'b1, 5'd3,  5'd9,  16'h0123,   -16'sh0456,  24'd2000,   24'd70000,  1'b1};
    tbl[10] = '{1'b0, 5'd7,  5'd31, -16'sh0010, 16'h0200,    24'h001000, 24'h00ff00, 1'b1};
    tbl[11] = '{1'b1, 5'd0,  5'd31, 16'd0,      16'h7fff,    24'd255,    -24'sd1,    1'b1};
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [vec_w-1:0] vec;
    logic [out_w-1:0] held;
    seed       = 32'ha1a8_14f1;
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    acc_valid  = 1'b0;
    acc_vector = '0;
    cfg_mode   = 1'b0;
    cfg_lo     = '0;
    cfg_hi     = '0;
    cfg_b0     = '0;
    cfg_b1     = '0;
    load_table();

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // reset values
    @(negedge clk);
    checks += 2;
    assert (out_valid == 1'b0) else begin
      mismatches++;
      $display("MISMATCH out_valid exp 0x0 got 0x%0h", out_valid);
    end
    assert (out_vector == '0) else begin
      mismatches++;
      $display("MISMATCH out_vector exp 0x0 got 0x%0h", out_vector);
    end
    read_check(`PP_CTRL, 32'h0, 1'b0);
    read_check(`PP_SCALE, 32'h0, 1'b0);
    read_check(`PP_BIAS, 32'h0, 1'b0);
    read_check(`PP_COUNT, 32'h0, 1'b0);

    // readback
    write_reg(`PP_CTRL, 32'h0000_0001, 1'b0);
    write_reg(`PP_SCALE, 32'h0000_1a05, 1'b0);
    write_reg(`PP_BIAS, 32'hff80_0123, 1'b0);
    read_check(`PP_CTRL, 32'h0000_0001, 1'b0);
    read_check(`PP_SCALE, 32'h0000_1a05, 1'b0);
    read_check(`PP_BIAS, 32'hff80_0123, 1'b0);

    // error responses, contents untouched
    read_check(8'h10, 32'h0, 1'b1);
    write_reg(8'h10, 32'hdead_beef, 1'b1);
    write_reg(`PP_COUNT, 32'h0000_0055, 1'b1);
    read_check(`PP_CTRL, 32'h0000_0001, 1'b0);
    read_check(`PP_SCALE, 32'h0000_1a05, 1'b0);
    read_check(`PP_BIAS, 32'hff80_0123, 1'b0);
    read_check(`PP_COUNT, 32'h0, 1'b0);

    // one vector per row
    for (int r = 0; r < num_rows; r++) begin
      program_config(tbl[r].mode, tbl[r].lo, tbl[r].hi, tbl[r].b0, tbl[r].b1);
      build_vector(tbl[r].g0, tbl[r].g1, tbl[r].fill, 1'b0, vec);
      send_vector(vec);
      end_stream();
      drain();
    end

    // back-to-back burst
    program_config(1'b1, 5'd4, 5'd8, 16'h0040, 16'hff80);
    for (int i = 0; i < 6; i++) begin
      build_vector('0, '0, 1'b1, 1'b1, vec);
      send_vector(vec);
    end
    end_stream();
    drain();

    // idle gap with a new scale set, output must hold
    @(negedge clk);
    held = out_vector;
    program_config(1'b1, 5'd2, 5'd5, 16'hfff0, 16'h0020);
    repeat (8) begin
      @(negedge clk);
      checks += 2;
      assert (out_valid == 1'b0) else begin
        mismatches++;
        $display("MISMATCH out_valid exp 0x0 got 0x%0h", out_valid);
      end
      assert (out_vector == held) else begin
        mismatches++;
        $display("MISMATCH out_vector exp 0x%0h got 0x%0h", held, out_vector);
      end
    end

    // second burst
    for (int i = 0; i < 3; i++) begin
      build_vector('0, '0, 1'b1, 1'b1, vec);
      send_vector(vec);
    end
    end_stream();
    drain();

    read_check(`PP_COUNT, 32'(sent), 1'b0);

    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errs);
    if (mismatches + other_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: include/pp_regs.svh
`ifndef PP_REGS_SVH
`define PP_REGS_SVH

//////////////////////////////////////////////////////////////////////
// apb register map of the post-processing stage
//////////////////////////////////////////////////////////////////////

// control, bit 0 selects the arithmetic mode
`define PP_CTRL   8'h00
// low and high shift amounts
`define PP_SCALE  8'h04
// signed bias pair, group 0 in the low half
`define PP_BIAS   8'h08
// read-only count of produced output vectors
`define PP_COUNT  8'h0C

// ctrl fields
// 0 = 8x8 (low scale on both groups), 1 = 1x8 (high scale on group 1)
`define PP_CTRL_MODE_BIT 0

`endif

// File: list.f
+incdir+include
verilog/pp_pkg.sv
verilog/pp_apb_regs.sv
verilog/pp_bias_add.sv
verilog/pp_relu_quant.sv
verilog/pp_top.sv
dv/tb_pp_top.sv

// File: verilog/pp_apb_regs.sv
`timescale 1ns/1ps

module pp_apb_regs (
  input  logic                                    clk,
  input  logic                                    rst_n,
  // apb slave
  input  logic                                    psel,
  input  logic                                    penable,
  input  logic                                    pwrite,
  input  logic [pp_pkg::apb_addr_width-1:0]       paddr,
  input  logic [pp_pkg::apb_data_width-1:0]       pwdata,
  output logic [pp_pkg::apb_data_width-1:0]       prdata,
  output logic                                    pready,
  output logic                                    pslverr,
  // output vector strobe from the quantizer
  input  logic                                    out_valid,
  // configuration to the data path
  output logic                                    mode,
  output logic [pp_pkg::shift_width-1:0]          scale_lo,
  output logic [pp_pkg::shift_width-1:0]          scale_hi,
  output logic signed [pp_pkg::bias_width-1:0]    bias0,
  output logic signed [pp_pkg::bias_width-1:0]    bias1
);

  import pp_pkg::*;

  `include "pp_regs.svh"

  cfg_word_u                 ctrl_q;
  cfg_word_u                 scale_q;
  cfg_word_u                 bias_q;
  logic [apb_data_width-1:0] count_q;

  logic access;
  logic addr_hit;
  logic wr_en;

  //////////////////////////////////////////////////////////////////////
  // access decode
  //////////////////////////////////////////////////////////////////////

  // access phase, no wait states
  assign access = psel & penable;
  assign pready = 1'b1;

  assign addr_hit = (paddr == `PP_CTRL) || (paddr == `PP_SCALE) ||
                    (paddr == `PP_BIAS) || (paddr == `PP_COUNT);

  // unmapped offset, or count written
  assign pslverr = access & (~addr_hit | (pwrite & (paddr == `PP_COUNT)));

  assign wr_en = access & pwrite & ~pslverr;

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q.raw  <= '0;
      scale_q.raw <= '0;
      bias_q.raw  <= '0;
    end else if (wr_en) begin
      // whole word kept, fields decoded below
      case (paddr)
        `PP_CTRL:  ctrl_q.raw  <= pwdata;
        `PP_SCALE: scale_q.raw <= pwdata;
        `PP_BIAS:  bias_q.raw  <= pwdata;
        default: ;
      endcase
    end
  end

  // vectors produced, wraps at 2^32
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (out_valid) begin
      count_q <= count_q + 1'b1;
    end
  end

  // read mux
  always_comb begin
    case (paddr)
      `PP_CTRL:  prdata = ctrl_q.raw;
      `PP_SCALE: prdata = scale_q.raw;
      `PP_BIAS:  prdata = bias_q.raw;
      `PP_COUNT: prdata = count_q;
      default:   prdata = '0;
    endcase
  end

  // field views
  assign mode     = ctrl_q.raw[`PP_CTRL_MODE_BIT];
  assign scale_lo = scale_q.scale.scale_lo;
  assign scale_hi = scale_q.scale.scale_hi;
  assign bias0    = bias_q.bias.bias0;
  assign bias1    = bias_q.bias.bias1;

  // an erroring access leaves the config untouched
  a_no_write_on_err: assert property (
    @(posedge clk) disable iff (!rst_n)
    pslverr |=> ($stable(ctrl_q.raw) && $stable(scale_q.raw) && $stable(bias_q.raw))
  ) else $error("config register changed after an erroring access");

endmodule

// File: verilog/pp_bias_add.sv
`timescale 1ns/1ps

module pp_bias_add #(
  parameter int unsigned lanes_per_group = 4
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // accumulator stream from the array
  input  logic                                   acc_valid,
  input  logic [pp_pkg::num_groups*lanes_per_group*pp_pkg::acc_width-1:0]
                                                 acc_vector,
  // per-group bias
  input  logic signed [pp_pkg::bias_width-1:0]   bias0,
  input  logic signed [pp_pkg::bias_width-1:0]   bias1,
  // biased stream
  output logic                                   sum_valid,
  output logic [pp_pkg::num_groups*lanes_per_group*pp_pkg::sum_width-1:0]
                                                 sum_vector
);

  import pp_pkg::*;

  localparam int unsigned num_lanes = num_groups * lanes_per_group;

  logic [num_lanes*sum_width-1:0] sum_next;

  //////////////////////////////////////////////////////////////////////
  // lane adders
  //////////////////////////////////////////////////////////////////////

  // group 0 in the low lanes
  for (genvar grp = 0; grp < num_groups; grp++) begin : g_grp
    logic signed [bias_width-1:0] grp_bias;

    assign grp_bias = (grp == 0) ? bias0 : bias1;

    for (genvar ln = 0; ln < lanes_per_group; ln++) begin : g_lane
      localparam int unsigned idx = grp * lanes_per_group + ln;

      logic signed [acc_width-1:0] acc_lane;
      logic signed [sum_width-1:0] lane_sum;

      assign acc_lane = acc_vector[idx*acc_width +: acc_width];
      // both sides signed, so both get sign-extended to sum_width
      assign lane_sum = acc_lane + grp_bias;

      assign sum_next[idx*sum_width +: sum_width] = lane_sum;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= acc_valid;
    end
  end

  // payload, captured only with a valid vector
  always_ff @(posedge clk) begin
    if (acc_valid) begin
      sum_vector <= sum_next;
    end
  end

  // stream flag must be driven once out of reset
  a_acc_valid_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(acc_valid)
  ) else $error("acc_valid unknown after reset");

endmodule

// File: verilog/pp_pkg.sv
package pp_pkg;

  //////////////////////////////////////////////////////////////////////
  // data path widths
  //////////////////////////////////////////////////////////////////////

  // one accumulator lane from the array, signed
  localparam int unsigned acc_width   = 24;
  // lane after bias add, headroom over acc_width
  localparam int unsigned sum_width   = 32;
  // quantized activation
  localparam int unsigned q_width     = 8;
  // shift amount, 0..31
  localparam int unsigned shift_width = 5;
  // per-group bias, signed
  localparam int unsigned bias_width  = 16;
  // two channel groups per output vector
  localparam int unsigned num_groups  = 2;

  // apb bus widths
  localparam int unsigned apb_addr_width = 8;
  localparam int unsigned apb_data_width = 32;

  //////////////////////////////////////////////////////////////////////
  // configuration word views
  //////////////////////////////////////////////////////////////////////

  // scale register: lo in [4:0], hi in [12:8]
  typedef struct packed {
    logic [apb_data_width-14:0] rsvd_hi;
    logic [shift_width-1:0]     scale_hi;
    logic [2:0]                 rsvd_lo;
    logic [shift_width-1:0]     scale_lo;
  } scale_fields_t;

  // bias register: group 1 in upper half
  typedef struct packed {
    logic signed [bias_width-1:0] bias1;
    logic signed [bias_width-1:0] bias0;
  } bias_fields_t;

  // raw apb word, read as scale or bias depending on offset
  typedef union packed {
    logic [apb_data_width-1:0] raw;
    scale_fields_t             scale;
    bias_fields_t              bias;
  } cfg_word_u;

endpackage

// File: verilog/pp_relu_quant.sv
`timescale 1ns/1ps

module pp_relu_quant #(
  parameter int unsigned lanes_per_group = 4
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // biased stream
  input  logic                                   sum_valid,
  input  logic [pp_pkg::num_groups*lanes_per_group*pp_pkg::sum_width-1:0]
                                                 sum_vector,
  // scale set and mode from the register block
  input  logic                                   mode,
  input  logic [pp_pkg::shift_width-1:0]         scale_lo,
  input  logic [pp_pkg::shift_width-1:0]         scale_hi,
  // quantized activations
  output logic                                   out_valid,
  output logic [pp_pkg::num_groups*lanes_per_group*pp_pkg::q_width-1:0]
                                                 out_vector
);

  import pp_pkg::*;

  localparam int unsigned num_lanes = num_groups * lanes_per_group;

  // 255 for an 8-bit activation
  localparam logic [q_width-1:0] q_max = '1;

  logic [shift_width-1:0]       scale_q [num_groups];
  logic [num_lanes*q_width-1:0] out_next;

  //////////////////////////////////////////////////////////////////////
  // scale set, registered alongside the sum
  //////////////////////////////////////////////////////////////////////

  // captured on the same edge as sum_vector in the bias stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scale_q[0] <= '0;
      scale_q[1] <= '0;
    end else begin
      // group 0 always takes the low scale
      scale_q[0] <= scale_lo;
      // group 1: low in 8x8, high in 1x8
      scale_q[1] <= mode ? scale_hi : scale_lo;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // relu, shift, saturate
  //////////////////////////////////////////////////////////////////////

  for (genvar grp = 0; grp < num_groups; grp++) begin : g_grp
    for (genvar ln = 0; ln < lanes_per_group; ln++) begin : g_lane
      localparam int unsigned idx = grp * lanes_per_group + ln;

      logic signed [sum_width-1:0] lane_sum;
      logic signed [sum_width-1:0] shifted;
      logic                        is_neg;
      logic                        over;
      logic [q_width-1:0]          q_lane;

      assign lane_sum = sum_vector[idx*sum_width +: sum_width];
      assign is_neg   = lane_sum[sum_width-1];

      // truncating shift, no rounding
      assign shifted = lane_sum >>> scale_q[grp];

      // anything above bit 7 set means > 255
      assign over = |shifted[sum_width-1:q_width];

      always_comb begin
        if (is_neg) begin
          q_lane = '0;
        end else if (over) begin
          q_lane = q_max;
        end else begin
          q_lane = shifted[q_width-1:0];
        end
      end

      assign out_next[idx*q_width +: q_width] = q_lane;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= sum_valid;
    end
  end

  // holds its value between valid sums
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_vector <= '0;
    end else if (sum_valid) begin
      out_vector <= out_next;
    end
  end

  // one cycle through this stage
  a_out_valid_lat: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid == $past(sum_valid)
  ) else $error("out_valid does not follow sum_valid by one cycle");

endmodule

// File: verilog/pp_top.sv
`timescale 1ns/1ps

module pp_top #(
  parameter int unsigned lanes_per_group = 4
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // apb configuration port
  input  logic                                   psel,
  input  logic                                   penable,
  input  logic                                   pwrite,
  input  logic [pp_pkg::apb_addr_width-1:0]      paddr,
  input  logic [pp_pkg::apb_data_width-1:0]      pwdata,
  output logic [pp_pkg::apb_data_width-1:0]      prdata,
  output logic                                   pready,
  output logic                                   pslverr,
  // accumulator stream in
  input  logic                                   acc_valid,
  input  logic [pp_pkg::num_groups*lanes_per_group*pp_pkg::acc_width-1:0]
                                                 acc_vector,
  // activation stream out, 2 cycles after acc_valid
  output logic                                   out_valid,
  output logic [pp_pkg::num_groups*lanes_per_group*pp_pkg::q_width-1:0]
                                                 out_vector
);

  import pp_pkg::*;

  // config from the register block
  logic                         mode;
  logic [shift_width-1:0]       scale_lo;
  logic [shift_width-1:0]       scale_hi;
  logic signed [bias_width-1:0] bias0;
  logic signed [bias_width-1:0] bias1;

  // between the two stages
  logic                                          sum_valid;
  logic [num_groups*lanes_per_group*sum_width-1:0] sum_vector;

  //////////////////////////////////////////////////////////////////////
  // register block
  //////////////////////////////////////////////////////////////////////

  pp_apb_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .out_valid (out_valid),
    .mode      (mode),
    .scale_lo  (scale_lo),
    .scale_hi  (scale_hi),
    .bias0     (bias0),
    .bias1     (bias1)
  );

  //////////////////////////////////////////////////////////////////////
  // data path
  //////////////////////////////////////////////////////////////////////

  // stage 1, bias
  pp_bias_add #(
    .lanes_per_group (lanes_per_group)
  ) u_bias_add (
    .clk        (clk),
    .rst_n      (rst_n),
    .acc_valid  (acc_valid),
    .acc_vector (acc_vector),
    .bias0      (bias0),
    .bias1      (bias1),
    .sum_valid  (sum_valid),
    .sum_vector (sum_vector)
  );

  // stage 2, relu and quantize
  pp_relu_quant #(
    .lanes_per_group (lanes_per_group)
  ) u_relu_quant (
    .clk        (clk),
    .rst_n      (rst_n),
    .sum_valid  (sum_valid),
    .sum_vector (sum_vector),
    .mode       (mode),
    .scale_lo   (scale_lo),
    .scale_hi   (scale_hi),
    .out_valid  (out_valid),
    .out_vector (out_vector)
  );

endmodule
